/* hdl/game_pkg.sv */
package game_pkg;

    // Remaining lives of the player
    typedef logic [2:0] lives_t;

    // Lives given at the start of every game
    localparam lives_t LIVES_AMOUNT = 3'd4;

    // Damage timeout, counted in video frames
    typedef logic [5:0] damage_frames_t;

    localparam damage_frames_t DAMAGE_FRAMES = 6'd30;

    // Fade flag flips when the low nibble of the timeout hits this value
    localparam logic [3:0] FADE_PHASE = 4'd8;

    // Cycle position inside one frame
    typedef logic [5:0] frame_cycles_t;

    // Shortened frame so simulation stays fast
    localparam int FRAME_CYCLES = 64;

    // One screen coordinate or size
    typedef logic [9:0] coord_t;

    // Bounding box of one object on screen
    typedef struct packed {
        coord_t left_x;
        coord_t top_y;
        coord_t width;
        coord_t height;
    } box_t;

    // Game control states
    typedef enum logic [1:0] {
        GAME_IDLE,
        GAME_PLAY,
        GAME_OVER
    } game_state_t;

endpackage

/* hdl/frame_tick.sv */
module frame_tick (
    input  logic clk,
    input  logic resetN,
    output logic start_of_frame
);

    localparam game_pkg::frame_cycles_t LAST_CYCLE =
        game_pkg::frame_cycles_t'(game_pkg::FRAME_CYCLES - 1);

    game_pkg::frame_cycles_t cycle_count;

    // Free-running position inside the current frame
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            cycle_count <= '0;
        end else begin
            if (cycle_count == LAST_CYCLE) begin
                cycle_count <= '0;
            end else begin
                cycle_count <= cycle_count + 1'b1;
            end
        end
    end

    // One-cycle strobe on the last cycle of every frame
    assign start_of_frame = (cycle_count == LAST_CYCLE);

endmodule

/* hdl/collision_detect.sv */
module collision_detect (
    input  logic            clk,
    input  logic            resetN,
    input  logic            enable,
    input  logic            missile_active,
    input  game_pkg::box_t  player_box,
    input  game_pkg::box_t  missile_box,
    output logic            missile_collision
);

    // One extra bit so the far edges cannot wrap
    localparam int EDGE_W = $bits(game_pkg::coord_t) + 1;

    logic [EDGE_W-1:0] player_left;
    logic [EDGE_W-1:0] player_top;
    logic [EDGE_W-1:0] player_right;
    logic [EDGE_W-1:0] player_bottom;
    logic [EDGE_W-1:0] missile_left;
    logic [EDGE_W-1:0] missile_top;
    logic [EDGE_W-1:0] missile_right;
    logic [EDGE_W-1:0] missile_bottom;
    logic              overlap_x;
    logic              overlap_y;

    assign player_left    = {1'b0, player_box.left_x};
    assign player_top     = {1'b0, player_box.top_y};
    assign player_right   = player_left + {1'b0, player_box.width};
    assign player_bottom  = player_top + {1'b0, player_box.height};

    assign missile_left   = {1'b0, missile_box.left_x};
    assign missile_top    = {1'b0, missile_box.top_y};
    assign missile_right  = missile_left + {1'b0, missile_box.width};
    assign missile_bottom = missile_top + {1'b0, missile_box.height};

    // Strict intersection, touching edges do not count
    assign overlap_x = (player_left < missile_right) && (missile_left < player_right);
    assign overlap_y = (player_top < missile_bottom) && (missile_top < player_bottom);

    // One pulse per cycle of contact
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            missile_collision <= 1'b0;
        end else begin
            missile_collision <= enable && missile_active && overlap_x && overlap_y;
        end
    end

endmodule

/* hdl/player_lives.sv */
module player_lives (
    input  logic                     clk,
    input  logic                     resetN,
    input  logic                     start_of_frame,
    input  logic                     missile_collision,
    input  logic                     restart,
    output game_pkg::lives_t         remaining_lives,
    output logic                     player_faded,
    output logic                     player_damaged,
    output logic                     player_dead
);

    game_pkg::damage_frames_t damage_timeout;
    logic                     timeout_done;

    assign timeout_done = (damage_timeout == '0);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            remaining_lives <= game_pkg::LIVES_AMOUNT;
            damage_timeout  <= '0;
            player_faded    <= 1'b0;
            player_damaged  <= 1'b0;
            player_dead     <= 1'b0;
        end else if (restart) begin
            // New game, everything back to its start value
            remaining_lives <= game_pkg::LIVES_AMOUNT;
            damage_timeout  <= '0;
            player_faded    <= 1'b0;
            player_damaged  <= 1'b0;
            player_dead     <= 1'b0;
        end else begin
            // Timeout over, player is vulnerable again
            if (timeout_done) begin
                player_faded   <= 1'b0;
                player_damaged <= 1'b0;
            end else if (start_of_frame) begin
                damage_timeout <= damage_timeout - 1'b1;
                // Blink while damaged
                if (damage_timeout[3:0] == game_pkg::FADE_PHASE) begin
                    player_faded <= ~player_faded;
                end
            end

            if (remaining_lives == '0) begin
                // Dead player stays faded and damaged for good
                player_dead    <= 1'b1;
                player_faded   <= 1'b1;
                player_damaged <= 1'b1;
            end else if (missile_collision && timeout_done) begin
                // Hit while vulnerable, lose a life and start the timeout
                remaining_lives <= remaining_lives - 1'b1;
                damage_timeout  <= game_pkg::DAMAGE_FRAMES;
                player_faded    <= 1'b1;
                player_damaged  <= 1'b1;
            end
        end
    end

endmodule

/* hdl/game_control.sv */
module game_control (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  start_button,
    input  logic                  player_dead,
    output game_pkg::game_state_t game_state,
    output logic                  game_running,
    output logic                  restart
);

    game_pkg::game_state_t next_state;
    logic                  start_game;

    // Start only counts outside of play
    assign start_game = start_button && (game_state != game_pkg::GAME_PLAY);

    always_comb begin
        next_state = game_state;
        case (game_state)
            game_pkg::GAME_IDLE: begin
                if (start_button) begin
                    next_state = game_pkg::GAME_PLAY;
                end
            end
            game_pkg::GAME_PLAY: begin
                // Ignore the stale dead flag while the restart is still being applied
                if (player_dead && !restart) begin
                    next_state = game_pkg::GAME_OVER;
                end
            end
            game_pkg::GAME_OVER: begin
                if (start_button) begin
                    next_state = game_pkg::GAME_PLAY;
                end
            end
            default: begin
                next_state = game_pkg::GAME_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            game_state <= game_pkg::GAME_IDLE;
            restart    <= 1'b0;
        end else begin
            game_state <= next_state;
            // Restart lines up with the first cycle of play
            restart    <= start_game;
        end
    end

    assign game_running = (game_state == game_pkg::GAME_PLAY);

endmodule

/* hdl/player_status_top.sv */
module player_status_top (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  start_button,
    input  logic                  missile_active,
    input  game_pkg::box_t        player_box,
    input  game_pkg::box_t        missile_box,
    output logic                  start_of_frame,
    output game_pkg::lives_t      remaining_lives,
    output logic                  player_faded,
    output logic                  player_damaged,
    output logic                  player_dead,
    output game_pkg::game_state_t game_state,
    output logic                  game_running
);

    logic missile_collision;
    logic restart;

    frame_tick u_frame_tick (
        .clk            (clk),
        .resetN         (resetN),
        .start_of_frame (start_of_frame)
    );

    // Hits only count while a game is running
    collision_detect u_collision_detect (
        .clk               (clk),
        .resetN            (resetN),
        .enable            (game_running),
        .missile_active    (missile_active),
        .player_box        (player_box),
        .missile_box       (missile_box),
        .missile_collision (missile_collision)
    );

    player_lives u_player_lives (
        .clk               (clk),
        .resetN            (resetN),
        .start_of_frame    (start_of_frame),
        .missile_collision (missile_collision),
        .restart           (restart),
        .remaining_lives   (remaining_lives),
        .player_faded      (player_faded),
        .player_damaged    (player_damaged),
        .player_dead       (player_dead)
    );

    game_control u_game_control (
        .clk          (clk),
        .resetN       (resetN),
        .start_button (start_button),
        .player_dead  (player_dead),
        .game_state   (game_state),
        .game_running (game_running),
        .restart      (restart)
    );

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic resetN
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        resetN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetN = 1'b1;
    end

endmodule

/* sim/player_status_checker.sv */
module player_status_checker (
    input logic             clk,
    input logic             resetN,
    input game_pkg::lives_t remaining_lives,
    input logic             player_faded,
    input logic             player_dead,
    input logic             restart,
    input logic             game_running
);

    // Failed assertions so far, read by the testbench
    int unsigned fail_count = 0;

    // Lives never go above the start value
    lives_in_range: assert property (
        @(posedge clk) disable iff (!resetN)
        remaining_lives <= game_pkg::LIVES_AMOUNT
    ) else begin
        fail_count = fail_count + 1;
        $error("remaining_lives above the start value");
    end

    // A dead player is always drawn faded
    dead_is_faded: assert property (
        @(posedge clk) disable iff (!resetN)
        player_dead |-> player_faded
    ) else begin
        fail_count = fail_count + 1;
        $error("player_dead without player_faded");
    end

    // Restart lasts one cycle
    restart_single_cycle: assert property (
        @(posedge clk) disable iff (!resetN)
        restart |=> !restart
    ) else begin
        fail_count = fail_count + 1;
        $error("restart held for more than one cycle");
    end

    // Play always begins together with a restart
    play_starts_with_restart: assert property (
        @(posedge clk) disable iff (!resetN)
        $rose(game_running) |-> restart
    ) else begin
        fail_count = fail_count + 1;
        $error("play state entered without a restart pulse");
    end

endmodule

// Watches the player_lives and game_control outputs where the top level joins them
bind player_status_top player_status_checker u_status_checker (
    .clk             (clk),
    .resetN          (resetN),
    .remaining_lives (remaining_lives),
    .player_faded    (player_faded),
    .player_dead     (player_dead),
    .restart         (restart),
    .game_running    (game_running)
);

/* sim/player_status_tb.sv */
module player_status_tb;

    localparam int CLK_PERIOD    = 20;
    localparam int NUM_TESTS     = 6;
    localparam int WATCHDOG_TIME = 40 * game_pkg::FRAME_CYCLES * CLK_PERIOD * NUM_TESTS;
    localparam int WAIT_LIMIT    = (game_pkg::DAMAGE_FRAMES + 2) * game_pkg::FRAME_CYCLES;
    localparam int RANDOM_CYCLES = 300;
    // Timeout values whose low nibble matches the fade phase
    localparam int FIRST_FADE    = 24;
    localparam int SECOND_FADE   = 8;

    logic                  clk;
    logic                  resetN;
    logic                  start_button;
    logic                  missile_active;
    game_pkg::box_t        player_box;
    game_pkg::box_t        missile_box;
    logic                  start_of_frame;
    game_pkg::lives_t      remaining_lives;
    logic                  player_faded;
    logic                  player_damaged;
    logic                  player_dead;
    game_pkg::game_state_t game_state;
    logic                  game_running;

    // Expected values from the model
    int                       exp_cycle;
    logic                     exp_sof;
    logic                     exp_collision;
    logic                     exp_restart;
    game_pkg::game_state_t    exp_state;
    game_pkg::lives_t         exp_lives;
    game_pkg::damage_frames_t exp_timeout;
    logic                     exp_faded;
    logic                     exp_damaged;
    logic                     exp_dead;

    integer seed = 32'h1252_5b58;
    int     frames_seen;
    int     toggle_at[$];

    tb_clock u_clock (
        .clk    (clk),
        .resetN (resetN)
    );

    player_status_top u_dut (
        .clk             (clk),
        .resetN          (resetN),
        .start_button    (start_button),
        .missile_active  (missile_active),
        .player_box      (player_box),
        .missile_box     (missile_box),
        .start_of_frame  (start_of_frame),
        .remaining_lives (remaining_lives),
        .player_faded    (player_faded),
        .player_damaged  (player_damaged),
        .player_dead     (player_dead),
        .game_state      (game_state),
        .game_running    (game_running)
    );

    // Strict intersection on both axes
    function automatic bit box_overlap(input game_pkg::box_t a, input game_pkg::box_t b);
        int a_right;
        int a_bottom;
        int b_right;
        int b_bottom;
        a_right  = int'(a.left_x) + int'(a.width);
        a_bottom = int'(a.top_y) + int'(a.height);
        b_right  = int'(b.left_x) + int'(b.width);
        b_bottom = int'(b.top_y) + int'(b.height);
        return (int'(a.left_x) < b_right) && (int'(b.left_x) < a_right)
            && (int'(a.top_y) < b_bottom) && (int'(b.top_y) < a_bottom);
    endfunction

    function automatic game_pkg::box_t make_box(input game_pkg::coord_t x, input game_pkg::coord_t y,
                                                input game_pkg::coord_t w, input game_pkg::coord_t h);
        game_pkg::box_t box;
        box.left_x = x;
        box.top_y  = y;
        box.width  = w;
        box.height = h;
        return box;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("MISMATCH %s: actual 0x%0h expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    // Stimulus tasks are entered just after a falling edge
    task automatic press_start();
        start_button = 1'b1;
        @(negedge clk);
        start_button = 1'b0;
    endtask

    task automatic hit_once();
        player_box     = make_box(10'd100, 10'd200, 10'd32, 10'd32);
        missile_box    = make_box(10'd110, 10'd210, 10'd4, 10'd8);
        missile_active = 1'b1;
        @(negedge clk);
        missile_active = 1'b0;
    endtask

    task automatic draw_random_boxes();
        player_box.left_x  = game_pkg::coord_t'($random(seed) & 32'h7f);
        player_box.top_y   = game_pkg::coord_t'($random(seed) & 32'h7f);
        player_box.width   = game_pkg::coord_t'(32'd1 + ($random(seed) & 32'h1f));
        player_box.height  = game_pkg::coord_t'(32'd1 + ($random(seed) & 32'h1f));
        missile_box.left_x = game_pkg::coord_t'($random(seed) & 32'h7f);
        missile_box.top_y  = game_pkg::coord_t'($random(seed) & 32'h7f);
        missile_box.width  = game_pkg::coord_t'(32'd1 + ($random(seed) & 32'h1f));
        missile_box.height = game_pkg::coord_t'(32'd1 + ($random(seed) & 32'h1f));
        missile_active     = (($random(seed) & 32'h3) != 32'h0);
    endtask

    task automatic wait_for_state(input game_pkg::game_state_t target);
        int cycles;
        cycles = 0;
        while (game_state != target) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure("game state never reached the expected value");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Counts frames and fade toggles until the damage timeout ends
    task automatic wait_damage_clear(input int hold_cycles);
        int   cycles;
        logic last_faded;
        cycles      = 0;
        frames_seen = 0;
        toggle_at.delete();
        last_faded  = player_faded;
        while (player_damaged) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure("damage timeout never ended");
            end
            if (player_faded != last_faded) begin
                toggle_at.push_back(frames_seen);
            end
            last_faded     = player_faded;
            missile_active = (cycles < hold_cycles);
            if (start_of_frame) begin
                frames_seen++;
            end
            @(negedge clk);
            cycles++;
        end
        missile_active = 1'b0;
    endtask

    assign exp_sof = (exp_cycle == game_pkg::FRAME_CYCLES - 1);

    // Model of the frame counter, collision register, control FSM and lives
    always @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            exp_cycle     <= 0;
            exp_collision <= 1'b0;
            exp_restart   <= 1'b0;
            exp_state     <= game_pkg::GAME_IDLE;
            exp_lives     <= game_pkg::LIVES_AMOUNT;
            exp_timeout   <= '0;
            exp_faded     <= 1'b0;
            exp_damaged   <= 1'b0;
            exp_dead      <= 1'b0;
        end else begin
            exp_cycle     <= exp_sof ? 0 : exp_cycle + 1;
            exp_collision <= (exp_state == game_pkg::GAME_PLAY) && missile_active
                             && box_overlap(player_box, missile_box);
            exp_restart   <= start_button && (exp_state != game_pkg::GAME_PLAY);
            case (exp_state)
                game_pkg::GAME_IDLE, game_pkg::GAME_OVER: begin
                    if (start_button) begin
                        exp_state <= game_pkg::GAME_PLAY;
                    end
                end
                game_pkg::GAME_PLAY: begin
                    if (exp_dead && !exp_restart) begin
                        exp_state <= game_pkg::GAME_OVER;
                    end
                end
                default: begin
                    exp_state <= game_pkg::GAME_IDLE;
                end
            endcase
            if (exp_restart) begin
                exp_lives   <= game_pkg::LIVES_AMOUNT;
                exp_timeout <= '0;
                exp_faded   <= 1'b0;
                exp_damaged <= 1'b0;
                exp_dead    <= 1'b0;
            end else begin
                if (exp_timeout == '0) begin
                    exp_faded   <= 1'b0;
                    exp_damaged <= 1'b0;
                end else if (start_of_frame) begin
                    exp_timeout <= exp_timeout - 1'b1;
                    if (exp_timeout[3:0] == game_pkg::FADE_PHASE) begin
                        exp_faded <= ~exp_faded;
                    end
                end
                // Later assignments win, as in the rules
                if (exp_lives == '0) begin
                    exp_dead    <= 1'b1;
                    exp_faded   <= 1'b1;
                    exp_damaged <= 1'b1;
                end else if (exp_collision && exp_timeout == '0) begin
                    exp_lives   <= exp_lives - 1'b1;
                    exp_timeout <= game_pkg::DAMAGE_FRAMES;
                    exp_faded   <= 1'b1;
                    exp_damaged <= 1'b1;
                end
            end
        end
    end

    // Values read here are those of the cycle that just ended
    always @(posedge clk) begin
        if (resetN) begin
            check_value("start_of_frame", 32'(start_of_frame), 32'(exp_sof));
            check_value("remaining_lives", 32'(remaining_lives), 32'(exp_lives));
            check_value("player_faded", 32'(player_faded), 32'(exp_faded));
            check_value("player_damaged", 32'(player_damaged), 32'(exp_damaged));
            check_value("player_dead", 32'(player_dead), 32'(exp_dead));
            check_value("game_state", 32'(game_state), 32'(exp_state));
            check_value("game_running", 32'(game_running),
                        32'(exp_state == game_pkg::GAME_PLAY));
            check_value("checker_failures", 32'(u_dut.u_status_checker.fail_count), 32'd0);
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        start_button   = 1'b0;
        missile_active = 1'b0;
        player_box     = make_box(10'd100, 10'd200, 10'd32, 10'd32);
        missile_box    = make_box(10'd600, 10'd400, 10'd4, 10'd8);
        @(posedge resetN);
        @(negedge clk);

        // Test 1 reset values, hits in idle do nothing
        check_value("remaining_lives", 32'(remaining_lives), 32'(game_pkg::LIVES_AMOUNT));
        check_value("player_damaged", 32'(player_damaged), 32'd0);
        check_value("game_state", 32'(game_state), 32'(game_pkg::GAME_IDLE));
        missile_box    = make_box(10'd110, 10'd210, 10'd4, 10'd8);
        missile_active = 1'b1;
        repeat (50) @(negedge clk);
        missile_active = 1'b0;
        check_value("remaining_lives", 32'(remaining_lives), 32'(game_pkg::LIVES_AMOUNT));

        // Test 2 one hit costs one life
        press_start();
        wait_for_state(game_pkg::GAME_PLAY);
        @(negedge clk);
        hit_once();
        check_value("player_damaged", 32'(player_damaged), 32'd0);
        @(negedge clk);
        check_value("remaining_lives", 32'(remaining_lives), 32'(game_pkg::LIVES_AMOUNT - 1));
        check_value("player_damaged", 32'(player_damaged), 32'd1);
        check_value("player_faded", 32'(player_faded), 32'd1);

        // Test 3 hits ignored while damaged, then the timeout runs out
        wait_damage_clear(200);
        check_value("damage_frames", 32'(frames_seen), 32'(game_pkg::DAMAGE_FRAMES));
        check_value("fade_toggles", 32'(toggle_at.size()), 32'd2);
        check_value("first_fade_frame", 32'(toggle_at[0]),
                    32'(game_pkg::DAMAGE_FRAMES - FIRST_FADE + 1));
        check_value("second_fade_frame", 32'(toggle_at[1]),
                    32'(game_pkg::DAMAGE_FRAMES - SECOND_FADE + 1));
        check_value("remaining_lives", 32'(remaining_lives), 32'(game_pkg::LIVES_AMOUNT - 1));

        // Test 4 random boxes, the model follows every cycle
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < RANDOM_CYCLES; i++) begin
                draw_random_boxes();
                @(negedge clk);
            end
            missile_active = 1'b0;
            repeat (2) @(negedge clk);
            wait_damage_clear(0);
        end

        // Test 5 hit until the game is over
        while (remaining_lives > game_pkg::lives_t'(1)) begin
            hit_once();
            @(negedge clk);
            wait_damage_clear(0);
        end
        hit_once();
        wait_for_state(game_pkg::GAME_OVER);
        check_value("player_dead", 32'(player_dead), 32'd1);
        check_value("game_running", 32'(game_running), 32'd0);
        repeat (3 * game_pkg::FRAME_CYCLES) @(negedge clk);
        check_value("player_faded", 32'(player_faded), 32'd1);
        check_value("game_state", 32'(game_state), 32'(game_pkg::GAME_OVER));

        // Test 6 restart from game over
        press_start();
        wait_for_state(game_pkg::GAME_PLAY);
        @(negedge clk);
        check_value("remaining_lives", 32'(remaining_lives), 32'(game_pkg::LIVES_AMOUNT));
        check_value("player_dead", 32'(player_dead), 32'd0);
        check_value("player_faded", 32'(player_faded), 32'd0);
        repeat (game_pkg::FRAME_CYCLES) @(negedge clk);
        check_value("game_state", 32'(game_state), 32'(game_pkg::GAME_PLAY));

        if (u_dut.u_status_checker.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            report_failure("assertion checker reported failures");
        end
    end

endmodule

/* src.f */
hdl/game_pkg.sv
hdl/frame_tick.sv
hdl/collision_detect.sv
hdl/player_lives.sv
hdl/game_control.sv
hdl/player_status_top.sv
sim/tb_clock.sv
sim/player_status_checker.sv
sim/player_status_tb.sv

/* Makefile */
TOP := player_status_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes
$(SIM): src.f $(shell cat src.f)
	verilator --binary --assert -j 0 --top-module $(TOP) -f src.f

# Assertion errors keep running so the testbench can report them
run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q '^TEST PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
